// ==== source/tomasulo_pkg.sv ====
package tomasulo_pkg;

    // Datapath sizes
    localparam int word_width = 32;
    localparam int num_regs   = 8;

    // Data word carried by the register file, the stations and the CDB
    typedef logic [word_width-1:0] word_t;

    typedef logic [2:0]  reg_idx_t;  // Architectural register r0..r7
    typedef logic [2:0]  rs_tag_t;   // Station entry that produces a value
    typedef logic [15:0] imm_t;      // Zero-extended on use

    // Highest tag is never an entry
    // A register or operand carrying it already holds its value
    localparam rs_tag_t TAG_NONE = 3'd7;

    typedef enum logic [2:0] {
        op_li  = 3'd0,  // Immediate into dest, sources ignored
        op_add = 3'd1,
        op_sub = 3'd2,
        op_and = 3'd3,
        op_xor = 3'd4,
        op_mul = 3'd5   // Low 32 bits of the product
    } alu_op_t;

    // Multiplies live in their own entries, everything else in the ALU ones
    function automatic logic is_mul(alu_op_t op);
        return op == op_mul;
    endfunction

    // Operand value at dispatch
    // Register file if nothing is pending, CDB if the producer finishes now
    function automatic word_t capture_value(rs_tag_t map_tag, word_t reg_value,
                                            logic cdb_valid, rs_tag_t cdb_tag,
                                            word_t cdb_value);
        word_t value;
        value = reg_value;
        if (map_tag != TAG_NONE && cdb_valid && map_tag == cdb_tag) begin
            value = cdb_value;
        end
        return value;
    endfunction

endpackage

// ==== source/map_table.sv ====
`timescale 1ns/1ps

module map_table (
    input  logic                                clock,
    input  logic                                reset,
    input  tomasulo_pkg::reg_idx_t              src1,
    input  tomasulo_pkg::reg_idx_t              src2,
    input  tomasulo_pkg::reg_idx_t              dest,
    input  logic                                alloc_valid,
    input  tomasulo_pkg::rs_tag_t               alloc_tag,
    input  logic                                cdb_valid,
    input  tomasulo_pkg::rs_tag_t               cdb_tag,
    output tomasulo_pkg::rs_tag_t               tag1,
    output tomasulo_pkg::rs_tag_t               tag2,
    output logic [tomasulo_pkg::num_regs-1:0]   write_mask
);
    import tomasulo_pkg::*;

    rs_tag_t tags [num_regs];  // Pending producer per register

    // Rename lookup for the instruction being dispatched
    assign tag1 = tags[src1];
    assign tag2 = tags[src2];

    // A broadcast retires the mapping that still names its tag,
    // unless the dispatch in this cycle renames the register again
    always_comb begin
        for (int i = 0; i < num_regs; i++) begin
            write_mask[i] = cdb_valid && tags[i] != TAG_NONE && tags[i] == cdb_tag
                            && !(alloc_valid && dest == reg_idx_t'(i));
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                tags[i] <= TAG_NONE;
            end
        end else begin
            for (int i = 0; i < num_regs; i++) begin
                if (write_mask[i]) begin
                    tags[i] <= TAG_NONE;  // Value now lives in reg_file
                end
            end
            if (alloc_valid) begin
                tags[dest] <= alloc_tag;  // Youngest writer wins
            end
        end
    end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                                clock,
    input  logic                                reset,
    input  tomasulo_pkg::reg_idx_t              src1,
    input  tomasulo_pkg::reg_idx_t              src2,
    input  tomasulo_pkg::reg_idx_t              read_index,
    input  logic [tomasulo_pkg::num_regs-1:0]   write_mask,
    input  tomasulo_pkg::word_t                 cdb_value,
    output tomasulo_pkg::word_t                 value1,
    output tomasulo_pkg::word_t                 value2,
    output tomasulo_pkg::word_t                 read_value
);
    import tomasulo_pkg::*;

    word_t regs [num_regs];

    // A same-cycle CDB write shows up in the reads one cycle later
    assign value1     = regs[src1];
    assign value2     = regs[src2];
    assign read_value = regs[read_index];  // Debug port

    // The mask already excludes stale tags and same-cycle renames
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_regs; i++) begin
                if (write_mask[i]) begin
                    regs[i] <= cdb_value;
                end
            end
        end
    end

endmodule

// ==== source/rs.sv ====
`timescale 1ns/1ps

module rs #(
    parameter int alu_entries = 3,
    parameter int mul_entries = 2
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    dispatch_valid,
    input  tomasulo_pkg::alu_op_t   dispatch_op,
    input  tomasulo_pkg::imm_t      dispatch_imm,
    input  tomasulo_pkg::rs_tag_t   tag1,
    input  tomasulo_pkg::rs_tag_t   tag2,
    input  tomasulo_pkg::word_t     value1,
    input  tomasulo_pkg::word_t     value2,
    input  logic                    cdb_valid,
    input  tomasulo_pkg::rs_tag_t   cdb_tag,
    input  tomasulo_pkg::word_t     cdb_value,
    output logic                    alloc_valid,
    output tomasulo_pkg::rs_tag_t   alloc_tag,
    output logic                    alu_slot_free,
    output logic                    mul_slot_free,
    output logic                    issue_valid,
    output tomasulo_pkg::rs_tag_t   issue_tag,
    output tomasulo_pkg::alu_op_t   issue_op,
    output tomasulo_pkg::word_t     issue_a,
    output tomasulo_pkg::word_t     issue_b
);
    import tomasulo_pkg::*;

    // ALU entries first and multiply entries above them
    localparam int num_entries = alu_entries + mul_entries;

    logic [num_entries-1:0] busy;    // Held from dispatch until own broadcast
    logic [num_entries-1:0] issued;  // Sent to exec_unit with the result still in flight
    alu_op_t                entry_op    [num_entries];
    rs_tag_t                entry_tag_a [num_entries];  // TAG_NONE once ready
    rs_tag_t                entry_tag_b [num_entries];
    word_t                  entry_val_a [num_entries];
    word_t                  entry_val_b [num_entries];

    logic [num_entries-1:0] wake_a;
    logic [num_entries-1:0] wake_b;

    logic    dispatch_mul;
    rs_tag_t cap_tag_a;
    rs_tag_t cap_tag_b;
    word_t   cap_val_a;
    word_t   cap_val_b;

    assign dispatch_mul = is_mul(dispatch_op);

    // Lowest free entry of the dispatched class
    always_comb begin
        alloc_valid = 1'b0;
        alloc_tag   = TAG_NONE;
        for (int i = num_entries - 1; i >= 0; i--) begin
            if (dispatch_valid && !busy[i] && ((i >= alu_entries) == dispatch_mul)) begin
                alloc_valid = 1'b1;
                alloc_tag   = rs_tag_t'(i);
            end
        end
    end

    always_comb begin
        alu_slot_free = 1'b0;
        mul_slot_free = 1'b0;
        for (int i = 0; i < num_entries; i++) begin
            if (!busy[i]) begin
                if (i < alu_entries) begin
                    alu_slot_free = 1'b1;
                end else begin
                    mul_slot_free = 1'b1;
                end
            end
        end
    end

    // Operand capture at dispatch
    always_comb begin
        cap_val_a = capture_value(tag1, value1, cdb_valid, cdb_tag, cdb_value);
        cap_val_b = capture_value(tag2, value2, cdb_valid, cdb_tag, cdb_value);
        cap_tag_a = (cdb_valid && tag1 == cdb_tag) ? TAG_NONE : tag1;
        cap_tag_b = (cdb_valid && tag2 == cdb_tag) ? TAG_NONE : tag2;
        if (dispatch_op == op_li) begin
            // Immediate rides in operand a with nothing to wait for
            cap_tag_a = TAG_NONE;
            cap_tag_b = TAG_NONE;
            cap_val_a = {16'h0000, dispatch_imm};
            cap_val_b = '0;
        end
    end

    // Waiting operands that the current broadcast completes
    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            wake_a[i] = cdb_valid && busy[i] && entry_tag_a[i] != TAG_NONE
                        && entry_tag_a[i] == cdb_tag;
            wake_b[i] = cdb_valid && busy[i] && entry_tag_b[i] != TAG_NONE
                        && entry_tag_b[i] == cdb_tag;
        end
    end

    // Issue picks the lowest ready entry not yet sent
    always_comb begin
        issue_valid = 1'b0;
        issue_tag   = TAG_NONE;
        issue_op    = op_li;
        issue_a     = '0;
        issue_b     = '0;
        for (int i = num_entries - 1; i >= 0; i--) begin
            if (busy[i] && !issued[i] && entry_tag_a[i] == TAG_NONE
                    && entry_tag_b[i] == TAG_NONE) begin
                issue_valid = 1'b1;
                issue_tag   = rs_tag_t'(i);
                issue_op    = entry_op[i];
                issue_a     = entry_val_a[i];
                issue_b     = entry_val_b[i];
            end
        end
    end

    // Entry control state
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy   <= '0;
            issued <= '0;
            for (int i = 0; i < num_entries; i++) begin
                entry_tag_a[i] <= TAG_NONE;
                entry_tag_b[i] <= TAG_NONE;
            end
        end else begin
            for (int i = 0; i < num_entries; i++) begin
                if (wake_a[i]) begin
                    entry_tag_a[i] <= TAG_NONE;
                end
                if (wake_b[i]) begin
                    entry_tag_b[i] <= TAG_NONE;
                end
                if (cdb_valid && cdb_tag == rs_tag_t'(i)) begin
                    busy[i]   <= 1'b0;  // Own result is out
                    issued[i] <= 1'b0;
                end
            end
            if (issue_valid) begin
                issued[issue_tag] <= 1'b1;
            end
            // Only a free entry is allocated, so no clash with the lines above
            if (alloc_valid) begin
                busy[alloc_tag]        <= 1'b1;
                issued[alloc_tag]      <= 1'b0;
                entry_tag_a[alloc_tag] <= cap_tag_a;
                entry_tag_b[alloc_tag] <= cap_tag_b;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        for (int i = 0; i < num_entries; i++) begin
            if (wake_a[i]) begin
                entry_val_a[i] <= cdb_value;
            end
            if (wake_b[i]) begin
                entry_val_b[i] <= cdb_value;
            end
        end
        if (alloc_valid) begin
            entry_op[alloc_tag]    <= dispatch_op;
            entry_val_a[alloc_tag] <= cap_val_a;
            entry_val_b[alloc_tag] <= cap_val_b;
        end
    end

endmodule

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  tomasulo_pkg::rs_tag_t   issue_tag,
    input  tomasulo_pkg::alu_op_t   issue_op,
    input  tomasulo_pkg::word_t     issue_a,
    input  tomasulo_pkg::word_t     issue_b,
    output logic                    cdb_valid,
    output tomasulo_pkg::rs_tag_t   cdb_tag,
    output tomasulo_pkg::word_t     cdb_value
);
    import tomasulo_pkg::*;

    word_t alu_result;

    // Stage one registers
    logic    s1_valid;
    rs_tag_t s1_tag;
    alu_op_t s1_op;
    word_t   s1_a;
    word_t   s1_b;
    word_t   s1_alu;

    word_t product;

    // Single-cycle operations resolved before stage one
    always_comb begin
        case (issue_op)
            op_li:   alu_result = issue_a;  // Immediate already in operand a
            op_add:  alu_result = issue_a + issue_b;
            op_sub:  alu_result = issue_a - issue_b;
            op_and:  alu_result = issue_a & issue_b;
            op_xor:  alu_result = issue_a ^ issue_b;
            default: alu_result = '0;       // Multiply finishes in stage two
        endcase
    end

    assign product = s1_a * s1_b;  // Truncates to the low word

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            cdb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_tag <= issue_tag;
        s1_op  <= issue_op;
        s1_a   <= issue_a;
        s1_b   <= issue_b;
        s1_alu <= alu_result;

        // Stage two onto the CDB
        cdb_tag   <= s1_tag;
        cdb_value <= is_mul(s1_op) ? product : s1_alu;
    end

endmodule

// ==== source/tomasulo_unit.sv ====
`timescale 1ns/1ps

module tomasulo_unit #(
    parameter int alu_entries = 3,
    parameter int mul_entries = 2  // Sum must stay at most 7
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    dispatch_valid,
    input  tomasulo_pkg::alu_op_t   dispatch_op,
    input  tomasulo_pkg::reg_idx_t  dispatch_dest,
    input  tomasulo_pkg::reg_idx_t  dispatch_src1,
    input  tomasulo_pkg::reg_idx_t  dispatch_src2,
    input  tomasulo_pkg::imm_t      dispatch_imm,
    output logic                    alu_slot_free,
    output logic                    mul_slot_free,
    output logic                    cdb_valid,
    output tomasulo_pkg::rs_tag_t   cdb_tag,
    output tomasulo_pkg::word_t     cdb_value,
    input  tomasulo_pkg::reg_idx_t  read_index,
    output tomasulo_pkg::word_t     read_value
);
    import tomasulo_pkg::*;

    // Rename and operand read
    rs_tag_t tag1;
    rs_tag_t tag2;
    word_t   value1;
    word_t   value2;
    logic [num_regs-1:0] write_mask;

    // Station to map table
    logic    alloc_valid;
    rs_tag_t alloc_tag;

    // Station to execute
    logic    issue_valid;
    rs_tag_t issue_tag;
    alu_op_t issue_op;
    word_t   issue_a;
    word_t   issue_b;

    map_table map_table_i (
        .clock       (clock),
        .reset       (reset),
        .src1        (dispatch_src1),
        .src2        (dispatch_src2),
        .dest        (dispatch_dest),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .tag1        (tag1),
        .tag2        (tag2),
        .write_mask  (write_mask)
    );

    reg_file reg_file_i (
        .clock      (clock),
        .reset      (reset),
        .src1       (dispatch_src1),
        .src2       (dispatch_src2),
        .read_index (read_index),
        .write_mask (write_mask),
        .cdb_value  (cdb_value),
        .value1     (value1),
        .value2     (value2),
        .read_value (read_value)
    );

    rs #(
        .alu_entries (alu_entries),
        .mul_entries (mul_entries)
    ) rs_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_imm   (dispatch_imm),
        .tag1           (tag1),
        .tag2           (tag2),
        .value1         (value1),
        .value2         (value2),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .alloc_valid    (alloc_valid),
        .alloc_tag      (alloc_tag),
        .alu_slot_free  (alu_slot_free),
        .mul_slot_free  (mul_slot_free),
        .issue_valid    (issue_valid),
        .issue_tag      (issue_tag),
        .issue_op       (issue_op),
        .issue_a        (issue_a),
        .issue_b        (issue_b)
    );

    exec_unit exec_unit_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

endmodule

// ==== verif/tomasulo_unit_tb.sv ====
`timescale 1ns/1ps

module tomasulo_unit_tb;
    import tomasulo_pkg::*;

    localparam int alu_entries  = 3;
    localparam int mul_entries  = 2;
    localparam int wait_limit   = 50;  // Cycles allowed for one wait
    localparam int random_count = 40;

    typedef struct {
        alu_op_t  op;
        reg_idx_t dest;
        reg_idx_t src1;
        reg_idx_t src2;
        imm_t     imm;
        int       gap;  // Idle cycles after the strobe
    } row_t;

    logic     clock = 1'b0;
    logic     reset;
    logic     dispatch_valid;
    alu_op_t  dispatch_op;
    reg_idx_t dispatch_dest;
    reg_idx_t dispatch_src1;
    reg_idx_t dispatch_src2;
    imm_t     dispatch_imm;
    logic     alu_slot_free;
    logic     mul_slot_free;
    logic     cdb_valid;
    rs_tag_t  cdb_tag;
    word_t    cdb_value;
    reg_idx_t read_index;
    word_t    read_value;

    row_t        rows [$];        // Stream being applied
    word_t       model_regs [8];  // Registers after in-order execution
    logic [31:0] rand_state;

    tomasulo_unit #(
        .alu_entries (alu_entries),
        .mul_entries (mul_entries)
    ) tomasulo_unit_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_dest  (dispatch_dest),
        .dispatch_src1  (dispatch_src1),
        .dispatch_src2  (dispatch_src2),
        .dispatch_imm   (dispatch_imm),
        .alu_slot_free  (alu_slot_free),
        .mul_slot_free  (mul_slot_free),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .read_index     (read_index),
        .read_value     (read_value)
    );

    always #50 clock = ~clock;  // 100 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // In-order result of one instruction
    function automatic word_t reference_result(alu_op_t op, word_t a, word_t b, imm_t imm);
        word_t result;
        case (op)
            op_li:   result = {16'h0000, imm};
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_and:  result = a & b;
            op_xor:  result = a ^ b;
            op_mul:  result = a * b;  // Low word only
            default: result = '0;
        endcase
        return result;
    endfunction

    function automatic row_t make_row(alu_op_t op, reg_idx_t dest, reg_idx_t src1,
                                      reg_idx_t src2, imm_t imm, int gap);
        row_t row;
        row.op   = op;
        row.dest = dest;
        row.src1 = src1;
        row.src2 = src2;
        row.imm  = imm;
        row.gap  = gap;
        return row;
    endfunction

    function automatic void add_row(alu_op_t op, reg_idx_t dest, reg_idx_t src1,
                                    reg_idx_t src2, imm_t imm, int gap);
        rows.push_back(make_row(op, dest, src1, src2, imm, gap));
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compare_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h",
                                     name, actual, expected));
        end
    endtask

    task automatic compare_tag(input string name, input rs_tag_t actual,
                               input rs_tag_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h",
                                     name, actual, expected));
        end
    endtask

    task automatic compare_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h",
                                     name, actual, expected));
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_for_slot(input logic mul_class);
        int cycles;
        cycles = 0;
        while (!(mul_class ? mul_slot_free : alu_slot_free)) begin
            if (cycles >= wait_limit) begin
                if (mul_class) begin
                    report_failure("Timed out waiting for a free multiply slot");
                end else begin
                    report_failure("Timed out waiting for a free ALU slot");
                end
            end
            next_cycle();
            cycles++;
        end
    endtask

    // Raises the strobe and runs the instruction through the model
    task automatic start_dispatch(input row_t row);
        wait_for_slot(row.op == op_mul);
        dispatch_valid = 1'b1;
        dispatch_op    = row.op;
        dispatch_dest  = row.dest;
        dispatch_src1  = row.src1;
        dispatch_src2  = row.src2;
        dispatch_imm   = row.imm;
        model_regs[row.dest] = reference_result(row.op, model_regs[row.src1],
                                                model_regs[row.src2], row.imm);
    endtask

    task automatic dispatch_row(input row_t row);
        start_dispatch(row);
        next_cycle();
        dispatch_valid = 1'b0;
        for (int i = 0; i < row.gap; i++) begin
            next_cycle();
        end
    endtask

    task automatic apply_rows();
        for (int i = 0; i < rows.size(); i++) begin
            dispatch_row(rows[i]);
        end
        rows.delete();
    endtask

    task automatic drain_and_check(input string stream);
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        // A busy unit never leaves the CDB idle for more than two cycles
        while (quiet < 4 || !alu_slot_free || !mul_slot_free) begin
            if (cycles >= wait_limit * 4) begin
                report_failure($sformatf("Timed out draining the unit after the %s stream",
                                         stream));
            end
            next_cycle();
            cycles++;
            quiet = cdb_valid ? 0 : quiet + 1;
        end
        for (int i = 0; i < 8; i++) begin
            read_index = reg_idx_t'(i);
            #1;
            compare_word($sformatf("read_value r%0d after %s", i, stream),
                         read_value, model_regs[i]);
        end
        next_cycle();
    endtask

    // Unit must be idle, so the strobe issues at once
    task automatic check_broadcast(input row_t row, input rs_tag_t expected_tag);
        int cycles;
        start_dispatch(row);
        next_cycle();
        dispatch_valid = 1'b0;
        cycles = 1;
        while (!cdb_valid) begin
            if (cycles >= 8) begin
                report_failure("No broadcast within 8 cycles of a dispatch on an idle unit");
            end
            next_cycle();
            cycles++;
        end
        if (cycles != 3) begin
            report_failure($sformatf("Broadcast came %0d cycles after the strobe instead of 3",
                                     cycles));
        end
        compare_tag("cdb_tag", cdb_tag, expected_tag);
        compare_word("cdb_value", cdb_value, model_regs[row.dest]);
    endtask

    task automatic build_random_rows(input int count);
        logic [31:0] fields;
        logic [31:0] extra;
        for (int i = 0; i < count; i++) begin
            rand_state = xorshift32(rand_state);
            fields     = rand_state;
            rand_state = xorshift32(rand_state);
            extra      = rand_state;
            add_row(alu_op_t'(3'(fields[31:16] % 16'd6)), fields[2:0], fields[5:3],
                    fields[8:6], extra[15:0], (extra[17:16] == 2'b11) ? 2 : 0);
        end
    endtask

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = op_li;
        dispatch_dest  = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        dispatch_imm   = '0;
        read_index     = '0;
        rand_state     = 32'h681f_cc22;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        compare_flag("cdb_valid", cdb_valid, 1'b0);
        compare_flag("alu_slot_free", alu_slot_free, 1'b1);
        compare_flag("mul_slot_free", mul_slot_free, 1'b1);
        drain_and_check("reset");

        // Lone instructions take the lowest entry of their class
        check_broadcast(make_row(op_li, 3'd1, 3'd0, 3'd0, 16'h1234, 0), rs_tag_t'(0));
        drain_and_check("li latency");
        check_broadcast(make_row(op_mul, 3'd2, 3'd1, 3'd1, 16'h0000, 0),
                        rs_tag_t'(alu_entries));
        drain_and_check("mul latency");

        add_row(op_li,  3'd6, 3'd0, 3'd0, 16'hbeef, 2);  // add below catches it on the CDB
        add_row(op_add, 3'd7, 3'd6, 3'd6, 16'h0000, 0);
        add_row(op_li,  3'd1, 3'd0, 3'd0, 16'h0005, 0);
        add_row(op_li,  3'd2, 3'd0, 3'd0, 16'h0009, 0);
        add_row(op_add, 3'd3, 3'd1, 3'd2, 16'h0000, 0);
        add_row(op_mul, 3'd4, 3'd3, 3'd1, 16'h0000, 0);
        add_row(op_sub, 3'd5, 3'd4, 3'd2, 16'h0000, 0);
        add_row(op_xor, 3'd0, 3'd5, 3'd7, 16'h0000, 0);
        apply_rows();
        drain_and_check("dependency chain");

        add_row(op_li,  3'd3, 3'd0, 3'd0, 16'h0007, 0);
        add_row(op_mul, 3'd4, 3'd3, 3'd3, 16'h0000, 0);  // Older write that still waits
        add_row(op_li,  3'd4, 3'd0, 3'd0, 16'h0055, 0);
        add_row(op_add, 3'd5, 3'd4, 3'd3, 16'h0000, 0);
        apply_rows();
        drain_and_check("write after write");

        add_row(op_li,  3'd1, 3'd0, 3'd0, 16'h0003, 0);
        add_row(op_mul, 3'd2, 3'd1, 3'd1, 16'h0000, 0);
        add_row(op_mul, 3'd5, 3'd2, 3'd1, 16'h0000, 0);
        apply_rows();
        compare_flag("mul_slot_free", mul_slot_free, 1'b0);
        wait_for_slot(1'b1);  // Frees up after the broadcasts
        add_row(op_mul, 3'd6, 3'd5, 3'd2, 16'h0000, 0);
        apply_rows();
        drain_and_check("multiply fill");

        build_random_rows(random_count);
        apply_rows();
        drain_and_check("random");

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== tomasulo_unit.f ====
source/tomasulo_pkg.sv
source/map_table.sv
source/reg_file.sv
source/rs.sv
source/exec_unit.sv
source/tomasulo_unit.sv
verif/tomasulo_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tomasulo_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tomasulo_unit_tb \
    -f tomasulo_unit.f \
    -o tomasulo_unit_sim

./obj_dir/tomasulo_unit_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi
